// File: include/dtlb_macros.svh
`ifndef DTLB_MACROS_SVH
`define DTLB_MACROS_SVH

// Number of fully associative TLB entries
`define DTLB_ENTRIES 8

// Outstanding misses towards the level-two TLB
`define DTLB_MSHR_ENTRIES 4

// Sv39 splits the VPN into three levels of this width
`define VPN_LVL_W 9

// Physical page number width
`define PPN_W 44

// Address space identifier width, as in satp
`define ASID_W 16

// Tag of the load/store queue slot
`define LSQ_ADDR_W 4

`endif

// File: hdl/dtlb_pkg.sv
`include "dtlb_macros.svh"

package dtlb_pkg;

  // VPN[2] is the top level of the page table walk
  typedef logic [2:0][`VPN_LVL_W-1:0] vpn_t;
  typedef logic [`PPN_W-1:0] ppn_t;
  typedef logic [`ASID_W-1:0] asid_t;

  // Size of the page held by an entry
  typedef enum logic [1:0] {
    kibi_page,
    mebi_page,
    gibi_page
  } page_type_e;

  // Privilege mode, already filtered by MPRV
  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_s = 2'b01,
    priv_m = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    flush_none,
    flush_all,
    flush_asid,
    flush_page
  } flush_e;

  typedef enum logic {
    exc_none,
    exc_page_fault
  } exc_e;

  // PTE permission bits kept in the TLB
  typedef struct packed {
    logic glob;
    logic user;
    logic read;
    logic write;
    logic exec;
    logic dirty;
  } pte_flags_t;

  // Context from the CSRs
  typedef struct packed {
    logic  sum;
    logic  mxr;
    priv_e priv;
    asid_t asid;
  } csr_ctx_t;

  // sfence.vma style flush command
  typedef struct packed {
    flush_e kind;
    asid_t  asid;
    vpn_t   vpn;
  } flush_req_t;

  // Load/store queue translation request
  typedef struct packed {
    logic                   valid;
    vpn_t                   vpn;
    logic                   is_store;
    logic [`LSQ_ADDR_W-1:0] lsq_addr;
  } lsq_req_t;

  // Answer to the queue, from a hit or from a returning miss
  typedef struct packed {
    logic                   valid;
    ppn_t                   ppn;
    exc_e                   exc;
    logic                   was_store;
    logic [`LSQ_ADDR_W-1:0] lsq_addr;
  } lsq_ans_t;

  // Wake-up of queue entries waiting on a VPN
  typedef struct packed {
    logic valid;
    vpn_t vpn;
  } lsq_wup_t;

  typedef struct packed {
    logic valid;
    vpn_t vpn;
  } l2_req_t;

  typedef struct packed {
    logic       valid;
    vpn_t       vpn;
    ppn_t       ppn;
    exc_e       exc;
    page_type_e page_type;
    pte_flags_t flags;
  } l2_ans_t;

  typedef struct packed {
    logic       valid;
    vpn_t       vpn;
    ppn_t       ppn;
    asid_t      asid;
    page_type_e page_type;
    pte_flags_t flags;
  } tlb_entry_t;

  // VPN compare at a page size, superpages ignore the lower levels
  function automatic logic vpn_match(input page_type_e pt, input vpn_t a, input vpn_t b);
    logic match;
    case (pt)
      gibi_page: match = (a[2] == b[2]);
      mebi_page: match = (a[2:1] == b[2:1]);
      default:   match = (a == b);
    endcase
    return match;
  endfunction

endpackage

// File: hdl/dtlb_plru.sv
`timescale 1ns/1ns
`include "dtlb_macros.svh"

module dtlb_plru #(
  parameter int unsigned N = `DTLB_ENTRIES
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic [N-1:0] valid_vec_i,
  input  logic [N-1:0] hit_vec_i,
  input  logic         touch_i,
  input  logic         fill_i,
  output logic [N-1:0] victim_vec_o
);

  localparam int unsigned LOG2_N = $clog2(N);

  // Heap ordered tree, node k has children 2k+1 and 2k+2
  // A set bit means the victim lies in the right subtree
  logic [N-2:0]      tree_q;
  logic [N-2:0]      tree_d;
  logic [N-1:0]      invalid_vec;
  logic [N-1:0]      first_inv_vec;
  logic [N-1:0]      tree_vec;
  logic [LOG2_N-1:0] tree_idx;
  logic [LOG2_N-1:0] hit_idx;
  logic [LOG2_N-1:0] victim_idx;
  logic [LOG2_N-1:0] upd_idx;

  // Walk from the root along the tree bits
  always_comb begin : tree_walk
    int unsigned node;
    node = 0;
    for (int unsigned lvl = 0; lvl < LOG2_N; lvl++) begin
      node = 2 * node + 1 + int'(tree_q[node]);
    end
    tree_idx = LOG2_N'(node - (N - 1));
    tree_vec = '0;
    tree_vec[tree_idx] = 1'b1;
  end

  // Free slots are filled first, lowest index wins
  assign invalid_vec   = ~valid_vec_i;
  assign first_inv_vec = invalid_vec & (~invalid_vec + N'(1));
  assign victim_vec_o  = (|invalid_vec) ? first_inv_vec : tree_vec;

  // One-hot to index
  always_comb begin
    hit_idx    = '0;
    victim_idx = '0;
    for (int unsigned k = 0; k < N; k++) begin
      if (hit_vec_i[k]) hit_idx = LOG2_N'(k);
      if (victim_vec_o[k]) victim_idx = LOG2_N'(k);
    end
  end

  // Point every node on the path away from the used leaf
  always_comb begin : tree_update
    int unsigned node;
    tree_d  = tree_q;
    upd_idx = fill_i ? victim_idx : hit_idx;
    node    = 0;
    for (int unsigned lvl = 0; lvl < LOG2_N; lvl++) begin
      tree_d[node] = ~upd_idx[LOG2_N-1-lvl];
      node = 2 * node + 1 + int'(upd_idx[LOG2_N-1-lvl]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tree_q <= '0;
    end else if (touch_i || fill_i) begin
      tree_q <= tree_d;
    end
  end

endmodule

// File: hdl/dtlb_entry_array.sv
`timescale 1ns/1ns
`include "dtlb_macros.svh"

module dtlb_entry_array (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dtlb_pkg::csr_ctx_t   csr_i,
  // Lookup of an accepted queue request
  input  logic                 lookup_i,
  input  dtlb_pkg::lsq_req_t   req_i,
  // Flush command, kind flush_none when idle
  input  dtlb_pkg::flush_req_t flush_i,
  // Fill from a matching level-two answer
  input  logic                 fill_i,
  input  dtlb_pkg::l2_ans_t    ans_i,
  output logic                 hit_o,
  output dtlb_pkg::ppn_t       ppn_o,
  output dtlb_pkg::exc_e       exc_o
);

  import dtlb_pkg::*;

  localparam int unsigned N = `DTLB_ENTRIES;

  tlb_entry_t       entry_q [N];
  tlb_entry_t       hit_entry;
  tlb_entry_t       fill_entry;
  logic [N-1:0]     valid_vec;
  logic [N-1:0]     hit_vec;
  logic [N-1:0]     victim_vec;
  logic [N-1:0]     flush_vec;
  logic             touch;

  // Hit vector, entry must be valid and global or of the current ASID
  always_comb begin
    for (int unsigned k = 0; k < N; k++) begin
      valid_vec[k] = entry_q[k].valid;
      hit_vec[k]   = lookup_i && entry_q[k].valid &&
                     (entry_q[k].flags.glob || (entry_q[k].asid == csr_i.asid)) &&
                     vpn_match(entry_q[k].page_type, entry_q[k].vpn, req_i.vpn);
    end
  end

  // Select the hit entry
  always_comb begin
    hit_entry = '0;
    for (int unsigned k = 0; k < N; k++) begin
      if (hit_vec[k]) hit_entry = entry_q[k];
    end
  end

  assign hit_o = |hit_vec;
  assign ppn_o = hit_entry.ppn;

  // Permission checks, first failing rule raises the fault
  always_comb begin
    exc_o = exc_none;
    if (hit_o) begin
      // Execute-only page, readable only with MXR
      if (!hit_entry.flags.read && !csr_i.mxr) begin
        exc_o = exc_page_fault;
      // Store to a read-only page
      end else if (req_i.is_store && !hit_entry.flags.write) begin
        exc_o = exc_page_fault;
      // Store to a clean page, dirty bit update left to software
      end else if (req_i.is_store && !hit_entry.flags.dirty) begin
        exc_o = exc_page_fault;
      // S mode on a user page needs SUM
      end else if (hit_entry.flags.user && (csr_i.priv == priv_s) && !csr_i.sum) begin
        exc_o = exc_page_fault;
      // U mode never reaches supervisor pages
      end else if (!hit_entry.flags.user && (csr_i.priv == priv_u)) begin
        exc_o = exc_page_fault;
      end
    end
  end

  // Faulting accesses leave the replacement state alone
  assign touch = hit_o && (exc_o == exc_none);

  // Entries cleared by the flush command
  always_comb begin
    for (int unsigned k = 0; k < N; k++) begin
      case (flush_i.kind)
        flush_all:  flush_vec[k] = 1'b1;
        // Global mappings survive
        flush_asid: flush_vec[k] = !entry_q[k].flags.glob &&
                                   (entry_q[k].asid == flush_i.asid);
        // Compared at the entry's own page size
        flush_page: flush_vec[k] = vpn_match(entry_q[k].page_type, entry_q[k].vpn,
                                             flush_i.vpn);
        default:    flush_vec[k] = 1'b0;
      endcase
    end
  end

  // New entry from the level-two answer, tagged with the current ASID
  always_comb begin
    fill_entry           = '0;
    fill_entry.valid     = 1'b1;
    fill_entry.vpn       = ans_i.vpn;
    fill_entry.ppn       = ans_i.ppn;
    fill_entry.asid      = csr_i.asid;
    fill_entry.page_type = ans_i.page_type;
    fill_entry.flags     = ans_i.flags;
  end

  dtlb_plru #(
    .N(N)
  ) plru_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_vec_i (valid_vec),
    .hit_vec_i   (hit_vec),
    .touch_i     (touch),
    .fill_i      (fill_i),
    .victim_vec_o(victim_vec)
  );

  // Entry storage, flush before fill
  for (genvar k = 0; k < N; k++) begin : gen_entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        entry_q[k] <= '0;
      end else if (flush_vec[k]) begin
        entry_q[k].valid <= 1'b0;
      end else if (fill_i && victim_vec[k]) begin
        entry_q[k] <= fill_entry;
      end
    end
  end

endmodule

// File: hdl/dtlb_mshr.sv
`timescale 1ns/1ns
`include "dtlb_macros.svh"

module dtlb_mshr #(
  parameter int unsigned DEPTH = `DTLB_MSHR_ENTRIES
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Branch mispredict, drops every outstanding miss
  input  logic              clr_i,
  input  logic              lookup_i,
  input  dtlb_pkg::vpn_t    req_vpn_i,
  input  logic              add_i,
  input  dtlb_pkg::l2_ans_t ans_i,
  output dtlb_pkg::l2_req_t l2_req_o,
  input  logic              l2_req_rdy_i,
  output logic              lookup_hit_o,
  output logic              ans_hit_o,
  output logic              full_o
);

  import dtlb_pkg::*;

  // Waiting is set once the request went to the level-two TLB
  typedef struct packed {
    logic valid;
    logic waiting;
    vpn_t vpn;
  } mshr_entry_t;

  mshr_entry_t      entry_q [DEPTH];
  logic [DEPTH-1:0] valid_vec;
  logic [DEPTH-1:0] pend_vec;
  logic [DEPTH-1:0] issue_vec;
  logic [DEPTH-1:0] alloc_vec;
  logic [DEPTH-1:0] lookup_vec;
  logic [DEPTH-1:0] ans_vec;
  logic             issue_taken;

  always_comb begin
    for (int unsigned k = 0; k < DEPTH; k++) begin
      valid_vec[k]  = entry_q[k].valid;
      // Allocated but not sent yet
      pend_vec[k]   = entry_q[k].valid && !entry_q[k].waiting;
      // Duplicate miss, full VPN compare
      lookup_vec[k] = lookup_i && entry_q[k].valid && (entry_q[k].vpn == req_vpn_i);
      // Superpage answer covers every miss inside it
      ans_vec[k]    = ans_i.valid && entry_q[k].valid &&
                      vpn_match(ans_i.page_type, entry_q[k].vpn, ans_i.vpn);
    end
  end

  assign lookup_hit_o = |lookup_vec;
  assign ans_hit_o    = |ans_vec;
  assign full_o       = &valid_vec;

  // Lowest pending entry is issued
  assign issue_vec = pend_vec & (~pend_vec + DEPTH'(1));
  // Lowest free entry is allocated
  assign alloc_vec = ~valid_vec & (valid_vec + DEPTH'(1));

  always_comb begin
    l2_req_o       = '0;
    l2_req_o.valid = |pend_vec;
    for (int unsigned k = 0; k < DEPTH; k++) begin
      if (issue_vec[k]) l2_req_o.vpn = entry_q[k].vpn;
    end
  end

  assign issue_taken = l2_req_o.valid && l2_req_rdy_i;

  // Clear, then free on answer, then issue, then allocate
  for (genvar k = 0; k < DEPTH; k++) begin : gen_entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        entry_q[k] <= '0;
      end else if (clr_i) begin
        entry_q[k].valid   <= 1'b0;
        entry_q[k].waiting <= 1'b0;
      end else if (ans_vec[k]) begin
        entry_q[k].valid   <= 1'b0;
        entry_q[k].waiting <= 1'b0;
      end else if (issue_taken && issue_vec[k]) begin
        entry_q[k].waiting <= 1'b1;
      end else if (add_i && alloc_vec[k]) begin
        entry_q[k].valid   <= 1'b1;
        entry_q[k].waiting <= 1'b0;
        entry_q[k].vpn     <= req_vpn_i;
      end
    end
  end

endmodule

// File: hdl/dtlb_l1.sv
`timescale 1ns/1ns

module dtlb_l1 (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clr_mshr_i,
  input  dtlb_pkg::csr_ctx_t   csr_i,
  input  dtlb_pkg::flush_req_t flush_i,
  // Load/store queue side
  input  dtlb_pkg::lsq_req_t   lsq_req_i,
  output logic                 req_rdy_o,
  output dtlb_pkg::lsq_ans_t   lsq_ans_o,
  output dtlb_pkg::lsq_wup_t   lsq_wup_o,
  // Level-two TLB side
  output dtlb_pkg::l2_req_t    l2_req_o,
  input  logic                 l2_req_rdy_i,
  input  dtlb_pkg::l2_ans_t    l2_ans_i
);

  import dtlb_pkg::*;

  logic    flush_act;
  logic    req_act;
  logic    fill;
  logic    arr_hit;
  ppn_t    arr_ppn;
  exc_e    arr_exc;
  logic    mshr_add;
  logic    mshr_lookup_hit;
  logic    mshr_ans_hit;
  logic    mshr_full;
  l2_ans_t mshr_ans;

  // Fixed priority, flush then level-two answer then queue
  assign flush_act = (flush_i.kind != flush_none);
  assign req_rdy_o = !flush_act && !l2_ans_i.valid && !mshr_full;
  assign req_act   = lsq_req_i.valid && req_rdy_o;

  // Answer is dropped during a flush
  always_comb begin
    mshr_ans       = l2_ans_i;
    mshr_ans.valid = l2_ans_i.valid && !flush_act;
  end

  // Faulting translations are not cached
  assign fill     = mshr_ans_hit && (l2_ans_i.exc == exc_none);
  // New miss only if not already outstanding
  assign mshr_add = req_act && !arr_hit && !mshr_lookup_hit;

  dtlb_entry_array entry_array_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .csr_i   (csr_i),
    .lookup_i(req_act),
    .req_i   (lsq_req_i),
    .flush_i (flush_i),
    .fill_i  (fill),
    .ans_i   (l2_ans_i),
    .hit_o   (arr_hit),
    .ppn_o   (arr_ppn),
    .exc_o   (arr_exc)
  );

  dtlb_mshr mshr_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clr_i       (clr_mshr_i),
    .lookup_i    (req_act),
    .req_vpn_i   (lsq_req_i.vpn),
    .add_i       (mshr_add),
    .ans_i       (mshr_ans),
    .l2_req_o    (l2_req_o),
    .l2_req_rdy_i(l2_req_rdy_i),
    .lookup_hit_o(mshr_lookup_hit),
    .ans_hit_o   (mshr_ans_hit),
    .full_o      (mshr_full)
  );

  // Wake-up and answer, returning miss or same-cycle hit
  always_comb begin
    lsq_wup_o = '0;
    lsq_ans_o = '0;
    if (mshr_ans_hit) begin
      lsq_wup_o.valid = 1'b1;
      lsq_wup_o.vpn   = l2_ans_i.vpn;
      // Queue matches on the wake-up VPN, no slot tag here
      lsq_ans_o.valid = 1'b1;
      lsq_ans_o.ppn   = l2_ans_i.ppn;
      lsq_ans_o.exc   = l2_ans_i.exc;
    end else if (req_act && arr_hit) begin
      lsq_ans_o.valid     = 1'b1;
      lsq_ans_o.ppn       = arr_ppn;
      lsq_ans_o.exc       = arr_exc;
      lsq_ans_o.was_store = lsq_req_i.is_store;
      lsq_ans_o.lsq_addr  = lsq_req_i.lsq_addr;
    end
  end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS = 100
) (
  output logic clk_o
);

  // Free running clock, first rising edge after half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

// File: sim/dtlb_l1_tb.sv
`timescale 1ns/1ns
`include "dtlb_macros.svh"

module dtlb_l1_tb;

  import dtlb_pkg::*;

  localparam int N          = `DTLB_ENTRIES;
  localparam int M          = `DTLB_MSHR_ENTRIES;
  localparam int LVL_W      = `VPN_LVL_W;
  localparam int ADDR_W     = `LSQ_ADDR_W;
  localparam int POOL       = 12;
  localparam int NUM_CYCLES = 2400;

  logic       clk;
  logic       rst_n;
  logic       clr_mshr;
  logic       l2_req_rdy;
  csr_ctx_t   csr;
  flush_req_t flush;
  lsq_req_t   lsq_req;
  l2_ans_t    l2_ans;
  logic       req_rdy;
  lsq_ans_t   lsq_ans;
  lsq_wup_t   lsq_wup;
  l2_req_t    l2_req;

  // Page table behind the level-two TLB with one mapping per VPN[2]
  ppn_t       pt_ppn   [POOL];
  page_type_e pt_type  [POOL];
  pte_flags_t pt_flags [POOL];
  exc_e       pt_exc   [POOL];

  // Reference model of the entries, the tree bits and the MSHR
  tlb_entry_t   m_ent    [N];
  logic [N-2:0] m_tree;
  logic         m_mvalid [M];
  logic         m_mwait  [M];
  vpn_t         m_mvpn   [M];

  // Level-two requests in flight are answered in order
  vpn_t rsp_vpn [$];
  int   rsp_due [$];

  int    cycle;
  int    errors;
  int    gaps;
  int    n_hit;
  int    n_wup;
  int    n_fault;
  int    n_full;
  string phase;

  tb_clock_gen #(
    .PERIOD_NS(100)
  ) clock_gen_inst (
    .clk_o(clk)
  );

  dtlb_l1 dtlb_l1_inst (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .clr_mshr_i  (clr_mshr),
    .csr_i       (csr),
    .flush_i     (flush),
    .lsq_req_i   (lsq_req),
    .req_rdy_o   (req_rdy),
    .lsq_ans_o   (lsq_ans),
    .lsq_wup_o   (lsq_wup),
    .l2_req_o    (l2_req),
    .l2_req_rdy_i(l2_req_rdy),
    .l2_ans_i    (l2_ans)
  );

  // Superpages compare only the upper levels
  function automatic logic page_hit(page_type_e pt, vpn_t page, vpn_t va);
    if (page[2] != va[2]) return 1'b0;
    if (pt == gibi_page) return 1'b1;
    if (page[1] != va[1]) return 1'b0;
    return (pt == mebi_page) || (page[0] == va[0]);
  endfunction

  // Fault rules in their order of priority
  function automatic exc_e perm_check(pte_flags_t f, csr_ctx_t c, logic st);
    if (!f.read && !c.mxr) return exc_page_fault;
    if (st && !f.write) return exc_page_fault;
    if (st && !f.dirty) return exc_page_fault;
    if (f.user && (c.priv == priv_s) && !c.sum) return exc_page_fault;
    if (!f.user && (c.priv == priv_u)) return exc_page_fault;
    return exc_none;
  endfunction

  // Leaf reached from the root where a set bit points right
  function automatic int tree_leaf(logic [N-2:0] t);
    int node;
    node = 0;
    while (node < N - 1) begin
      node = 2 * node + (t[node] ? 2 : 1);
    end
    return node - (N - 1);
  endfunction

  // Bisect the leaf range and point each node at the other half
  function automatic logic [N-2:0] tree_touch(logic [N-2:0] t, int leaf);
    logic [N-2:0] nt;
    int           node;
    int           lo;
    int           hi;
    int           mid;
    nt   = t;
    node = 0;
    lo   = 0;
    hi   = N;
    while (hi - lo > 1) begin
      mid = (lo + hi) / 2;
      if (leaf < mid) begin
        nt[node] = 1'b1;
        node     = 2 * node + 1;
        hi       = mid;
      end else begin
        nt[node] = 1'b0;
        node     = 2 * node + 2;
        lo       = mid;
      end
    end
    return nt;
  endfunction

  // Free entries first and the tree leaf otherwise
  function automatic int pick_victim();
    for (int k = 0; k < N; k++) begin
      if (!m_ent[k].valid) return k;
    end
    return tree_leaf(m_tree);
  endfunction

  // Low levels from a small set so that pages are reused
  function automatic vpn_t rand_vpn();
    vpn_t v;
    v[2] = LVL_W'($urandom_range(1, POOL));
    v[1] = LVL_W'($urandom_range(0, 1));
    v[0] = LVL_W'($urandom_range(0, 1));
    return v;
  endfunction

  task automatic build_table();
    for (int i = 0; i < POOL; i++) begin
      pt_ppn[i]   = ppn_t'({$urandom(), $urandom()});
      pt_type[i]  = page_type_e'(2'(i % 3));
      pt_flags[i] = pte_flags_t'(6'($urandom_range(0, 63)));
      // Mostly readable pages and some execute-only ones
      if (i % 4 != 3) pt_flags[i].read = 1'b1;
      pt_exc[i] = (i == 5) ? exc_page_fault : exc_none;
    end
  endtask

  task automatic reset_model();
    for (int k = 0; k < N; k++) begin
      m_ent[k] = '0;
    end
    for (int k = 0; k < M; k++) begin
      m_mvalid[k] = 1'b0;
      m_mwait[k]  = 1'b0;
      m_mvpn[k]   = '0;
    end
    m_tree = '0;
  endtask

  task automatic report_mismatch(string what, logic [127:0] exp, logic [127:0] act);
    errors++;
    $display("** Error [%s] %s: expected %h, actual %h", phase, what, exp, act);
  endtask

  // Predict this cycle's outputs, compare, then advance the model
  task automatic model_step();
    logic         flush_act;
    logic         exp_rdy;
    logic         req_act;
    logic         arr_hit;
    logic         mshr_full;
    logic         mshr_dup;
    logic         fill;
    logic [M-1:0] ans_vec;
    int           hit_k;
    int           vic;
    int           issue_k;
    int           alloc_k;
    exc_e         hit_exc;
    lsq_ans_t     e_ans;
    lsq_wup_t     e_wup;
    l2_req_t      e_l2;
    flush_act = (flush.kind != flush_none);
    mshr_full = 1'b1;
    mshr_dup  = 1'b0;
    issue_k   = -1;
    alloc_k   = -1;
    for (int k = 0; k < M; k++) begin
      if (!m_mvalid[k]) begin
        mshr_full = 1'b0;
        if (alloc_k < 0) alloc_k = k;
      end else if (!m_mwait[k] && issue_k < 0) begin
        issue_k = k;
      end
      if (m_mvalid[k] && (m_mvpn[k] == lsq_req.vpn)) mshr_dup = 1'b1;
      // Answers are lost while a flush is active
      ans_vec[k] = l2_ans.valid && !flush_act && m_mvalid[k] &&
                   page_hit(l2_ans.page_type, l2_ans.vpn, m_mvpn[k]);
    end
    exp_rdy = !flush_act && !l2_ans.valid && !mshr_full;
    req_act = lsq_req.valid && exp_rdy;
    hit_k   = -1;
    for (int k = 0; k < N; k++) begin
      if (m_ent[k].valid && (m_ent[k].flags.glob || (m_ent[k].asid == csr.asid)) &&
          page_hit(m_ent[k].page_type, m_ent[k].vpn, lsq_req.vpn)) hit_k = k;
    end
    arr_hit = req_act && (hit_k >= 0);
    hit_exc = exc_none;
    if (arr_hit) hit_exc = perm_check(m_ent[hit_k].flags, csr, lsq_req.is_store);
    e_ans = '0;
    e_wup = '0;
    e_l2  = '0;
    if (|ans_vec) begin
      e_wup.valid = 1'b1;
      e_wup.vpn   = l2_ans.vpn;
      e_ans.valid = 1'b1;
      e_ans.ppn   = l2_ans.ppn;
      e_ans.exc   = l2_ans.exc;
    end else if (arr_hit) begin
      e_ans.valid     = 1'b1;
      e_ans.ppn       = m_ent[hit_k].ppn;
      e_ans.exc       = hit_exc;
      e_ans.was_store = lsq_req.is_store;
      e_ans.lsq_addr  = lsq_req.lsq_addr;
    end
    e_l2.valid = (issue_k >= 0);
    if (e_l2.valid) e_l2.vpn = m_mvpn[issue_k];
    if (req_rdy !== exp_rdy) report_mismatch("req_rdy", 128'(exp_rdy), 128'(req_rdy));
    if (lsq_ans !== e_ans) report_mismatch("lsq_ans", 128'(e_ans), 128'(lsq_ans));
    if (lsq_wup !== e_wup) report_mismatch("lsq_wup", 128'(e_wup), 128'(lsq_wup));
    if ((l2_req.valid !== e_l2.valid) || (e_l2.valid && (l2_req.vpn !== e_l2.vpn))) begin
      report_mismatch("l2_req", 128'(e_l2), 128'(l2_req));
    end
    if (|ans_vec) n_wup++;
    if (arr_hit) n_hit++;
    if (arr_hit && (hit_exc == exc_page_fault)) n_fault++;
    if (mshr_full) n_full++;
    // Flush wins over fill in the entries
    vic  = pick_victim();
    fill = (|ans_vec) && (l2_ans.exc == exc_none);
    for (int k = 0; k < N; k++) begin
      if ((flush.kind == flush_all) ||
          ((flush.kind == flush_asid) && !m_ent[k].flags.glob &&
           (m_ent[k].asid == flush.asid)) ||
          ((flush.kind == flush_page) &&
           page_hit(m_ent[k].page_type, m_ent[k].vpn, flush.vpn))) begin
        m_ent[k].valid = 1'b0;
      end else if (fill && (k == vic)) begin
        m_ent[k].valid     = 1'b1;
        m_ent[k].vpn       = l2_ans.vpn;
        m_ent[k].ppn       = l2_ans.ppn;
        m_ent[k].asid      = csr.asid;
        m_ent[k].page_type = l2_ans.page_type;
        m_ent[k].flags     = l2_ans.flags;
      end
    end
    if (fill) begin
      m_tree = tree_touch(m_tree, vic);
    end else if (arr_hit && (hit_exc == exc_none)) begin
      m_tree = tree_touch(m_tree, hit_k);
    end
    // Clear then answer then issue then allocate in the MSHR
    for (int k = 0; k < M; k++) begin
      if (clr_mshr || ans_vec[k]) begin
        m_mvalid[k] = 1'b0;
        m_mwait[k]  = 1'b0;
      end else if (l2_req_rdy && (k == issue_k)) begin
        m_mwait[k] = 1'b1;
      end else if (req_act && !arr_hit && !mshr_dup && (k == alloc_k)) begin
        m_mvalid[k] = 1'b1;
        m_mwait[k]  = 1'b0;
        m_mvpn[k]   = lsq_req.vpn;
      end
    end
  endtask

  // New inputs for the next cycle driven right after the edge
  task automatic drive_cycle();
    l2_ans_t    a;
    flush_req_t f;
    lsq_req_t   r;
    csr_ctx_t   c;
    vpn_t       v;
    int         idx;
    int         flush_pct;
    int         clr_pct;
    if (cycle < 500) phase = "miss_hit";
    else if (cycle < 900) phase = "backpressure";
    else if (cycle < 1500) phase = "flush";
    else if (cycle < 1900) phase = "mshr_clear";
    else phase = "mixed";
    flush_pct = (phase == "flush") ? 6 : ((phase == "mixed") ? 2 : 0);
    clr_pct   = (phase == "mshr_clear") ? 3 : ((phase == "mixed") ? 1 : 0);
    // Responder answers from the page table once the delay is over
    a = '0;
    if ((rsp_vpn.size() > 0) && (rsp_due[0] <= cycle)) begin
      v = rsp_vpn.pop_front();
      void'(rsp_due.pop_front());
      idx = int'(v[2]) - 1;
      if ((idx < 0) || (idx >= POOL)) idx = 0;
      a.valid     = 1'b1;
      a.vpn       = v;
      a.ppn       = pt_ppn[idx];
      a.exc       = pt_exc[idx];
      a.page_type = pt_type[idx];
      a.flags     = pt_flags[idx];
    end
    // A flush would drop the answer and strand its MSHR entry
    f = '0;
    if (!a.valid && ($urandom_range(0, 99) < flush_pct)) begin
      f.kind = flush_e'(2'($urandom_range(1, 3)));
      f.asid = asid_t'($urandom_range(1, 2));
      f.vpn  = rand_vpn();
    end
    r = '0;
    if ($urandom_range(0, 99) < 60) begin
      r.valid    = 1'b1;
      r.vpn      = rand_vpn();
      r.is_store = 1'($urandom_range(0, 1));
      r.lsq_addr = ADDR_W'($urandom_range(0, 15));
    end
    c     = csr;
    c.sum = 1'($urandom_range(0, 1));
    c.mxr = 1'($urandom_range(0, 1));
    case ($urandom_range(0, 2))
      0:       c.priv = priv_u;
      1:       c.priv = priv_s;
      default: c.priv = priv_m;
    endcase
    // Context switch now and then
    if ($urandom_range(0, 49) == 0) c.asid = asid_t'((csr.asid == 1) ? 2 : 1);
    if (phase == "backpressure") l2_req_rdy <= ((cycle / 30) % 2 == 0);
    else l2_req_rdy <= ($urandom_range(0, 99) < 85);
    clr_mshr <= ($urandom_range(0, 99) < clr_pct);
    l2_ans   <= a;
    flush    <= f;
    lsq_req  <= r;
    csr      <= c;
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      model_step();
      if (l2_req.valid && l2_req_rdy) begin
        rsp_vpn.push_back(l2_req.vpn);
        rsp_due.push_back(cycle + $urandom_range(1, 4));
      end
    end
  end

  initial begin : watchdog
    #(NUM_CYCLES * 8 * 100);
    $display("Watchdog expired before the stimulus finished");
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h65d6));
    rst_n      = 1'b0;
    clr_mshr   = 1'b0;
    l2_req_rdy = 1'b0;
    csr        = '0;
    csr.asid   = 1;
    flush      = '0;
    lsq_req    = '0;
    l2_ans     = '0;
    cycle      = 0;
    errors     = 0;
    gaps       = 0;
    n_hit      = 0;
    n_wup      = 0;
    n_fault    = 0;
    n_full     = 0;
    phase      = "reset";
    build_table();
    reset_model();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    while (cycle < NUM_CYCLES) begin
      @(posedge clk);
      cycle++;
      drive_cycle();
    end
    // Idle tail with quiet inputs before the summary
    @(posedge clk);
    lsq_req  <= '0;
    flush    <= '0;
    clr_mshr <= 1'b0;
    l2_ans   <= '0;
    repeat (4) @(posedge clk);
    if (n_hit == 0) begin
      gaps++;
      $display("No TLB hit was seen during the run");
    end
    if (n_wup == 0) begin
      gaps++;
      $display("No wake-up from a level-two answer was seen");
    end
    if (n_fault == 0) begin
      gaps++;
      $display("No page fault on a hit was seen");
    end
    if (n_full == 0) begin
      gaps++;
      $display("The MSHR never became full");
    end
    $display("Summary: %0d mismatches, %0d coverage gaps (%0d hits, %0d wake-ups, %0d faults)",
             errors, gaps, n_hit, n_wup, n_fault);
    if ((errors == 0) && (gaps == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: dtlb_l1.f
+incdir+include
hdl/dtlb_pkg.sv
hdl/dtlb_plru.sv
hdl/dtlb_entry_array.sv
hdl/dtlb_mshr.sv
hdl/dtlb_l1.sv
sim/tb_clock_gen.sv
sim/dtlb_l1_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DTLB testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -j 0 -f dtlb_l1.f --top-module dtlb_l1_tb -o dtlb_l1_sim
./obj_dir/dtlb_l1_sim > sim.log 2>&1
cat sim.log
if grep -q "sim failed" sim.log; then
  echo "FAIL: see sim.log"
  exit 1
fi
echo "PASS"
